/* cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Lines per cache, both caches
`define CACHE_LINES 64

// Byte address fields
`define IDX_MSB 7
`define IDX_LSB 2
`define TAG_MSB 13
`define TAG_LSB 8

// Backing store
`define MEM_WORDS 4096

// Cycles from grant to response
`define MEM_LATENCY 3

`endif

/* cache_input.txt */
# paired(1 = start with next line) port(0 dcache, 1 icache) we addr wdata be exp_rdata exp_hit
# addr, wdata, be and exp_rdata in hex; exp_rdata is compared on reads only
0 0 1 0010 11223344 f 00000000 0
0 0 0 0010 00000000 0 11223344 1
0 0 1 0010 aabbccdd 5 00000000 1
0 0 0 0010 00000000 0 11bb33dd 1
0 0 1 0110 55667788 f 00000000 0
0 0 0 0010 00000000 0 11bb33dd 0
0 0 0 0110 00000000 0 55667788 0
0 0 0 0110 00000000 0 55667788 1
0 1 0 0010 00000000 0 11bb33dd 0
0 1 0 0010 00000000 0 11bb33dd 1
0 1 0 0110 00000000 0 55667788 0
0 1 0 0110 00000000 0 55667788 1
0 0 1 0040 0f1e2d3c f 00000000 0
0 0 1 0140 4b5a6978 f 00000000 0
1 1 0 0040 00000000 0 0f1e2d3c 0
0 0 1 0240 8796a5b4 f 00000000 0
1 1 0 0140 00000000 0 4b5a6978 0
0 0 0 0040 00000000 0 0f1e2d3c 0
0 0 0 0240 00000000 0 8796a5b4 0
0 0 1 0044 01020304 f 00000000 0
0 0 1 0044 ffeeddcc c 00000000 1
0 0 0 0044 00000000 0 ffee0304 1

/* cache_line_ram.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

module cache_line_ram #(
  parameter type ENTRY_T = logic [31:0]
) (
  input  logic                        clk_i,
  input  logic                        wr_en_i,
  input  logic [`IDX_MSB-`IDX_LSB:0]  wr_idx_i,
  input  ENTRY_T                      wr_entry_i,
  input  logic                        rd_en_i,
  input  logic [`IDX_MSB-`IDX_LSB:0]  rd_idx_i,
  output ENTRY_T                      rd_entry_o
);

  ENTRY_T mem_q [`CACHE_LINES];

  // Two-port array, read data one cycle after enable
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx_i] <= wr_entry_i;
    end
    if (rd_en_i) begin
      rd_entry_o <= mem_q[rd_idx_i];
    end
  end

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none
`include "cache_config.svh"

package cache_pkg;

  // CPU side
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [`TAG_MSB:0]    addr;
    logic [31:0]          wdata;
    logic [3:0]           be;
  } cpu_req_t;

  typedef struct packed {
    logic        done;
    logic [31:0] rdata;
  } cpu_rsp_t;

  // Memory side, word addressed
  typedef struct packed {
    logic                        req;
    logic                        we;
    logic [`TAG_MSB-`IDX_LSB:0]  addr;
    logic [31:0]                 wdata;
  } mem_req_t;

  typedef struct packed {
    logic        gnt;
    logic        valid;
    logic [31:0] rdata;
  } mem_rsp_t;

  // Array entries
  typedef struct packed {
    logic                        dirty;
    logic [`TAG_MSB-`TAG_LSB:0]  tag;
    logic [31:0]                 data;
  } dcache_line_t;

  typedef struct packed {
    logic [`TAG_MSB-`TAG_LSB:0]  tag;
    logic [31:0]                 data;
  } icache_line_t;

endpackage

`default_nettype wire

/* cache_props.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

module cache_props (
  input logic clk_i,
  input logic rst_i,
  input logic req_a_i,
  input logic gnt_a_i,
  input logic valid_a_i,
  input logic req_b_i,
  input logic gnt_b_i,
  input logic valid_b_i,
  input logic done_i,
  input logic busy_i
);

  one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    !(gnt_a_i && gnt_b_i)) else $error("two grants in one cycle");

  // Response strobe lands a fixed latency after the grant
  latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_a_i == $past(gnt_a_i, `MEM_LATENCY)) else $error("response a off its latency");
  latency_b: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_b_i == $past(gnt_b_i, `MEM_LATENCY)) else $error("response b off its latency");

  hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    req_a_i && !gnt_a_i |=> req_a_i) else $error("request a dropped before grant");
  hold_b: assert property (@(posedge clk_i) disable iff (rst_i)
    req_b_i && !gnt_b_i |=> req_b_i) else $error("request b dropped before grant");

  done_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |-> busy_i) else $error("done while not busy");

endmodule

bind memory_controller cache_props u_mem_props (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .req_a_i   (dc_req_i.req),
  .gnt_a_i   (dc_rsp_o.gnt),
  .valid_a_i (dc_rsp_o.valid),
  .req_b_i   (ic_req_i.req),
  .gnt_b_i   (ic_rsp_o.gnt),
  .valid_b_i (ic_rsp_o.valid),
  .done_i    (1'b0),
  .busy_i    (1'b0)
);

bind data_cache cache_props u_dcache_props (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .req_a_i   (mem_req_o.req),
  .gnt_a_i   (mem_rsp_i.gnt),
  .valid_a_i (mem_rsp_i.valid),
  .req_b_i   (1'b0),
  .gnt_b_i   (1'b0),
  .valid_b_i (1'b0),
  .done_i    (rsp_o.done),
  .busy_i    (busy_o)
);

`default_nettype wire

/* cache_subsystem.f */
+incdir+.
cache_pkg.sv
cache_line_ram.sv
data_cache.sv
instr_cache.sv
memory_controller.sv
cache_subsystem.sv
cache_props.sv
tb_clock_gen.sv
tb_checker.sv
tb_cache_subsystem.sv

/* cache_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

module cache_subsystem (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  cache_pkg::cpu_req_t  dcache_req_i,
  output cache_pkg::cpu_rsp_t  dcache_rsp_o,
  output logic                 dcache_busy_o,
  input  cache_pkg::cpu_req_t  icache_req_i,
  output cache_pkg::cpu_rsp_t  icache_rsp_o,
  output logic                 icache_busy_o
);
  import cache_pkg::*;

  mem_req_t                     dc_mem_req;
  mem_req_t                     ic_mem_req;
  mem_rsp_t                     dc_mem_rsp;
  mem_rsp_t                     ic_mem_rsp;

  logic                         dc_ram_wr_en;
  logic                         dc_ram_rd_en;
  logic [`IDX_MSB-`IDX_LSB:0]   dc_ram_wr_idx;
  logic [`IDX_MSB-`IDX_LSB:0]   dc_ram_rd_idx;
  dcache_line_t                 dc_ram_wr_entry;
  dcache_line_t                 dc_ram_rd_entry;

  logic                         ic_ram_wr_en;
  logic                         ic_ram_rd_en;
  logic [`IDX_MSB-`IDX_LSB:0]   ic_ram_wr_idx;
  logic [`IDX_MSB-`IDX_LSB:0]   ic_ram_rd_idx;
  icache_line_t                 ic_ram_wr_entry;
  icache_line_t                 ic_ram_rd_entry;

  data_cache u_data_cache (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (dcache_req_i),
    .rsp_o          (dcache_rsp_o),
    .busy_o         (dcache_busy_o),
    .mem_req_o      (dc_mem_req),
    .mem_rsp_i      (dc_mem_rsp),
    .ram_wr_en_o    (dc_ram_wr_en),
    .ram_wr_idx_o   (dc_ram_wr_idx),
    .ram_wr_entry_o (dc_ram_wr_entry),
    .ram_rd_en_o    (dc_ram_rd_en),
    .ram_rd_idx_o   (dc_ram_rd_idx),
    .ram_rd_entry_i (dc_ram_rd_entry)
  );

  cache_line_ram #(
    .ENTRY_T (dcache_line_t)
  ) u_dcache_ram (
    .clk_i      (clk_i),
    .wr_en_i    (dc_ram_wr_en),
    .wr_idx_i   (dc_ram_wr_idx),
    .wr_entry_i (dc_ram_wr_entry),
    .rd_en_i    (dc_ram_rd_en),
    .rd_idx_i   (dc_ram_rd_idx),
    .rd_entry_o (dc_ram_rd_entry)
  );

  instr_cache u_instr_cache (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (icache_req_i),
    .rsp_o          (icache_rsp_o),
    .busy_o         (icache_busy_o),
    .mem_req_o      (ic_mem_req),
    .mem_rsp_i      (ic_mem_rsp),
    .ram_wr_en_o    (ic_ram_wr_en),
    .ram_wr_idx_o   (ic_ram_wr_idx),
    .ram_wr_entry_o (ic_ram_wr_entry),
    .ram_rd_en_o    (ic_ram_rd_en),
    .ram_rd_idx_o   (ic_ram_rd_idx),
    .ram_rd_entry_i (ic_ram_rd_entry)
  );

  cache_line_ram #(
    .ENTRY_T (icache_line_t)
  ) u_icache_ram (
    .clk_i      (clk_i),
    .wr_en_i    (ic_ram_wr_en),
    .wr_idx_i   (ic_ram_wr_idx),
    .wr_entry_i (ic_ram_wr_entry),
    .rd_en_i    (ic_ram_rd_en),
    .rd_idx_i   (ic_ram_rd_idx),
    .rd_entry_o (ic_ram_rd_entry)
  );

  // Shared backing store
  memory_controller u_memory_controller (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .dc_req_i (dc_mem_req),
    .ic_req_i (ic_mem_req),
    .dc_rsp_o (dc_mem_rsp),
    .ic_rsp_o (ic_mem_rsp)
  );

endmodule

`default_nettype wire

/* data_cache.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

module data_cache (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  cache_pkg::cpu_req_t         req_i,
  output cache_pkg::cpu_rsp_t         rsp_o,
  output logic                        busy_o,
  output cache_pkg::mem_req_t         mem_req_o,
  input  cache_pkg::mem_rsp_t         mem_rsp_i,
  output logic                        ram_wr_en_o,
  output logic [`IDX_MSB-`IDX_LSB:0]  ram_wr_idx_o,
  output cache_pkg::dcache_line_t     ram_wr_entry_o,
  output logic                        ram_rd_en_o,
  output logic [`IDX_MSB-`IDX_LSB:0]  ram_rd_idx_o,
  input  cache_pkg::dcache_line_t     ram_rd_entry_i
);
  import cache_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITEBACK,
    ST_REFILL,
    ST_MERGE
  } state_t;

  state_t                       state_q;
  state_t                       state_d;
  cpu_req_t                     req_q;
  dcache_line_t                 line_q;
  logic [`CACHE_LINES-1:0]      valid_q;
  logic                         gnt_seen_q;

  logic [`IDX_MSB-`IDX_LSB:0]   idx;
  logic [`TAG_MSB-`TAG_LSB:0]   tag;
  logic                         hit;
  logic                         victim_dirty;
  logic [31:0]                  merged;

  assign idx          = req_q.addr[`IDX_MSB:`IDX_LSB];
  assign tag          = req_q.addr[`TAG_MSB:`TAG_LSB];
  assign hit          = valid_q[idx] && (ram_rd_entry_i.tag == tag);
  assign victim_dirty = valid_q[idx] && ram_rd_entry_i.dirty;

  // Byte merge, a read passes the line through unchanged
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (req_q.we && req_q.be[b]) begin
        merged[8*b +: 8] = req_q.wdata[8*b +: 8];
      end else begin
        merged[8*b +: 8] = line_q.data[8*b +: 8];
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_i.valid) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (hit) begin
          state_d = ST_MERGE;
        end else if (victim_dirty) begin
          state_d = ST_WRITEBACK;
        end else begin
          state_d = ST_REFILL;
        end
      end
      ST_WRITEBACK: begin
        if (mem_rsp_i.valid) begin
          state_d = ST_REFILL;
        end
      end
      ST_REFILL: begin
        if (mem_rsp_i.valid) begin
          state_d = ST_MERGE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      valid_q    <= '0;
      gnt_seen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mem_rsp_i.gnt) begin
        gnt_seen_q <= 1'b1;
      end else if (mem_rsp_i.valid) begin
        gnt_seen_q <= 1'b0;
      end
      if (state_q == ST_MERGE) begin
        valid_q[idx] <= 1'b1;
      end
    end
  end

  // Held access and the line being worked on
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i.valid) begin
      req_q <= req_i;
    end
    if (state_q == ST_LOOKUP) begin
      line_q <= ram_rd_entry_i;
    end else if (state_q == ST_REFILL && mem_rsp_i.valid) begin
      line_q <= '{dirty: 1'b0, tag: tag, data: mem_rsp_i.rdata};
    end
  end

  // Victim goes out first, then the refill read
  always_comb begin
    mem_req_o = '0;
    if (state_q == ST_WRITEBACK) begin
      mem_req_o.req   = !gnt_seen_q;
      mem_req_o.we    = 1'b1;
      mem_req_o.addr  = {line_q.tag, idx};
      mem_req_o.wdata = line_q.data;
    end else if (state_q == ST_REFILL) begin
      mem_req_o.req  = !gnt_seen_q;
      mem_req_o.addr = {tag, idx};
    end
  end

  assign busy_o       = (state_q != ST_IDLE);
  assign rsp_o        = '{done: (state_q == ST_MERGE), rdata: merged};
  assign ram_rd_en_o  = (state_q == ST_IDLE) && req_i.valid;
  assign ram_rd_idx_o = req_i.addr[`IDX_MSB:`IDX_LSB];

  // Line is rewritten in the done cycle, dirty once written
  assign ram_wr_en_o    = (state_q == ST_MERGE);
  assign ram_wr_idx_o   = idx;
  assign ram_wr_entry_o = '{dirty: line_q.dirty | req_q.we, tag: tag, data: merged};

endmodule

`default_nettype wire

/* instr_cache.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

module instr_cache (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  cache_pkg::cpu_req_t         req_i,
  output cache_pkg::cpu_rsp_t         rsp_o,
  output logic                        busy_o,
  output cache_pkg::mem_req_t         mem_req_o,
  input  cache_pkg::mem_rsp_t         mem_rsp_i,
  output logic                        ram_wr_en_o,
  output logic [`IDX_MSB-`IDX_LSB:0]  ram_wr_idx_o,
  output cache_pkg::icache_line_t     ram_wr_entry_o,
  output logic                        ram_rd_en_o,
  output logic [`IDX_MSB-`IDX_LSB:0]  ram_rd_idx_o,
  input  cache_pkg::icache_line_t     ram_rd_entry_i
);
  import cache_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL
  } state_t;

  state_t                       state_q;
  cpu_req_t                     req_q;
  logic [`CACHE_LINES-1:0]      valid_q;
  logic                         gnt_seen_q;
  logic                         done_q;
  logic [31:0]                  rdata_q;

  logic [`IDX_MSB-`IDX_LSB:0]   idx;
  logic [`TAG_MSB-`TAG_LSB:0]   tag;
  logic                         accept;
  logic                         hit;
  logic                         fill;

  assign idx    = req_q.addr[`IDX_MSB:`IDX_LSB];
  assign tag    = req_q.addr[`TAG_MSB:`TAG_LSB];
  assign accept = req_i.valid && !busy_o;
  assign hit    = valid_q[idx] && (ram_rd_entry_i.tag == tag);
  assign fill   = (state_q == ST_REFILL) && mem_rsp_i.valid;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      valid_q    <= '0;
      gnt_seen_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (mem_rsp_i.gnt) begin
        gnt_seen_q <= 1'b1;
      end else if (mem_rsp_i.valid) begin
        gnt_seen_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (hit) begin
            done_q  <= 1'b1;
            state_q <= ST_IDLE;
          end else begin
            state_q <= ST_REFILL;
          end
        end
        default: begin
          if (fill) begin
            done_q       <= 1'b1;
            valid_q[idx] <= 1'b1;
            state_q      <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Fetched word goes straight to the CPU
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (state_q == ST_LOOKUP) begin
      rdata_q <= ram_rd_entry_i.data;
    end else if (fill) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

  always_comb begin
    mem_req_o = '0;
    if (state_q == ST_REFILL) begin
      mem_req_o.req  = !gnt_seen_q;
      mem_req_o.addr = {tag, idx};
    end
  end

  // Busy covers the done cycle too
  assign busy_o         = (state_q != ST_IDLE) || done_q;
  assign rsp_o          = '{done: done_q, rdata: rdata_q};
  assign ram_rd_en_o    = accept;
  assign ram_rd_idx_o   = req_i.addr[`IDX_MSB:`IDX_LSB];
  assign ram_wr_en_o    = fill;
  assign ram_wr_idx_o   = idx;
  assign ram_wr_entry_o = '{tag: tag, data: mem_rsp_i.rdata};

endmodule

`default_nettype wire

/* memory_controller.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_config.svh"

module memory_controller (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  cache_pkg::mem_req_t  dc_req_i,
  input  cache_pkg::mem_req_t  ic_req_i,
  output cache_pkg::mem_rsp_t  dc_rsp_o,
  output cache_pkg::mem_rsp_t  ic_rsp_o
);
  import cache_pkg::*;

  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  logic [31:0]       mem_q [`MEM_WORDS];
  logic              busy_q;
  logic              last_ic_q;
  logic              owner_ic_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [31:0]       rdata_q;

  logic              gnt_dc;
  logic              gnt_ic;
  logic              rsp_valid;
  mem_req_t          sel_req;

  // Round robin, the side not granted last wins a tie
  assign gnt_dc    = !busy_q && dc_req_i.req && (!ic_req_i.req || last_ic_q);
  assign gnt_ic    = !busy_q && ic_req_i.req && !gnt_dc;
  assign sel_req   = gnt_ic ? ic_req_i : dc_req_i;
  assign rsp_valid = busy_q && (cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q     <= 1'b0;
      last_ic_q  <= 1'b0;
      owner_ic_q <= 1'b0;
      cnt_q      <= '0;
    end else if (gnt_dc || gnt_ic) begin
      busy_q     <= 1'b1;
      last_ic_q  <= gnt_ic;
      owner_ic_q <= gnt_ic;
      cnt_q      <= CNT_W'(`MEM_LATENCY - 1);
    end else if (rsp_valid) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Store is accessed at grant, read word waits out the latency
  always_ff @(posedge clk_i) begin
    if (gnt_dc || gnt_ic) begin
      if (sel_req.we) begin
        mem_q[sel_req.addr] <= sel_req.wdata;
      end
      rdata_q <= mem_q[sel_req.addr];
    end
  end

  assign dc_rsp_o = '{gnt: gnt_dc, valid: rsp_valid && !owner_ic_q, rdata: rdata_q};
  assign ic_rsp_o = '{gnt: gnt_ic, valid: rsp_valid && owner_ic_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f cache_subsystem.f \
  --top-module tb_cache_subsystem \
  -o sim_cache_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_cache_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* tb_cache_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cache_subsystem;
  import cache_pkg::*;

  typedef struct packed {
    logic        paired;
    logic        icache;
    logic        we;
    logic [13:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] exp_rdata;
    logic        exp_hit;
  } access_t;

  localparam int DRIVE_DELAY       = 2;
  localparam int RESET_WAIT_CYCLES = 20;
  localparam int BUSY_WAIT_CYCLES  = 50;
  localparam int DONE_WAIT_CYCLES  = 100;

  logic        clk;
  logic        rst;
  cpu_req_t    dcache_req;
  cpu_rsp_t    dcache_rsp;
  logic        dcache_busy;
  cpu_req_t    icache_req;
  cpu_rsp_t    icache_rsp;
  logic        icache_busy;
  logic [31:0] dcache_exp_rdata;
  logic        dcache_exp_hit;
  logic [31:0] icache_exp_rdata;
  logic        icache_exp_hit;
  int          error_count;
  int          check_count;
  int          fd;
  int          issued = 0;
  int          completed = 0;
  int          timeouts = 0;
  int          tb_errors = 0;

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  cache_subsystem dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .dcache_req_i  (dcache_req),
    .dcache_rsp_o  (dcache_rsp),
    .dcache_busy_o (dcache_busy),
    .icache_req_i  (icache_req),
    .icache_rsp_o  (icache_rsp),
    .icache_busy_o (icache_busy)
  );

  tb_checker u_checker (
    .clk_i              (clk),
    .rst_i              (rst),
    .dcache_req_i       (dcache_req),
    .dcache_rsp_i       (dcache_rsp),
    .dcache_busy_i      (dcache_busy),
    .dcache_exp_rdata_i (dcache_exp_rdata),
    .dcache_exp_hit_i   (dcache_exp_hit),
    .icache_req_i       (icache_req),
    .icache_rsp_i       (icache_rsp),
    .icache_busy_i      (icache_busy),
    .icache_exp_rdata_i (icache_exp_rdata),
    .icache_exp_hit_i   (icache_exp_hit),
    .error_count_o      (error_count),
    .check_count_o      (check_count)
  );

  // Skips comment and blank lines
  task automatic read_access(output access_t acc, output bit found);
    string       line;
    int          n;
    int          paired;
    int          port;
    int          we;
    int          exp_hit;
    logic [13:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] exp_rdata;
    found = 1'b0;
    acc   = '0;
    while (!found && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%d %d %d %h %h %h %h %d",
                    paired, port, we, addr, wdata, be, exp_rdata, exp_hit);
        if (n == 8) begin
          acc   = '{paired: paired[0], icache: port[0], we: we[0], addr: addr,
                    wdata: wdata, be: be, exp_rdata: exp_rdata, exp_hit: exp_hit[0]};
          found = 1'b1;
        end
      end
    end
  endtask

  task automatic drive_access(input access_t acc);
    int    waited;
    logic  busy;
    logic  done;
    string name;
    name   = acc.icache ? "icache" : "dcache";
    waited = 0;
    busy   = acc.icache ? icache_busy : dcache_busy;
    while (busy && waited < BUSY_WAIT_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      busy = acc.icache ? icache_busy : dcache_busy;
    end
    if (busy) begin
      timeouts++;
      $display("Timeout: %s port stayed busy, access to 0x%04h was never issued", name, acc.addr);
      return;
    end
    issued++;
    if (acc.icache) begin
      icache_exp_rdata = acc.exp_rdata;
      icache_exp_hit   = acc.exp_hit;
      icache_req = '{valid: 1'b1, we: 1'b0, addr: acc.addr, wdata: '0, be: '0};
    end else begin
      dcache_exp_rdata = acc.exp_rdata;
      dcache_exp_hit   = acc.exp_hit;
      dcache_req = '{valid: 1'b1, we: acc.we, addr: acc.addr, wdata: acc.wdata, be: acc.be};
    end
    done   = 1'b0;
    waited = 0;
    while (!done && waited < DONE_WAIT_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      done = acc.icache ? icache_rsp.done : dcache_rsp.done;
    end
    if (acc.icache) begin
      icache_req.valid = 1'b0;
    end else begin
      dcache_req.valid = 1'b0;
    end
    if (done) begin
      completed++;
    end else begin
      timeouts++;
      $display("Timeout: no done on %s port for access to 0x%04h", name, acc.addr);
    end
  endtask

  initial begin
    access_t first;
    access_t second;
    bit      got_first;
    bit      got_second;
    int      waited;
    dcache_req       = '0;
    icache_req       = '0;
    dcache_exp_rdata = '0;
    dcache_exp_hit   = 1'b0;
    icache_exp_rdata = '0;
    icache_exp_hit   = 1'b0;
    waited = 0;
    while (rst !== 1'b0 && waited < RESET_WAIT_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
    end
    if (rst !== 1'b0) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end else begin
      fd = $fopen("cache_input.txt", "r");
      if (fd == 0) begin
        tb_errors++;
        $display("Could not open cache_input.txt");
      end else begin
        read_access(first, got_first);
        while (got_first) begin
          if (first.paired) begin
            read_access(second, got_second);
            if (got_second) begin
              // Both ports start in the same cycle
              fork
                drive_access(first);
                drive_access(second);
              join
            end else begin
              tb_errors++;
              $display("Data file ends right after a paired line");
              drive_access(first);
            end
          end else begin
            drive_access(first);
          end
          read_access(first, got_first);
        end
        $fclose(fd);
      end
    end
    repeat (2) @(posedge clk);
    if (issued == 0) begin
      tb_errors++;
      $display("No access was issued from cache_input.txt");
    end
    if (check_count != completed) begin
      tb_errors++;
      $display("Checker judged %0d accesses but %0d completed", check_count, completed);
    end
    $display("Issued %0d, checked %0d, errors %0d, timeouts %0d",
             issued, check_count, error_count + tb_errors, timeouts);
    if (error_count + tb_errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  cache_pkg::cpu_req_t  dcache_req_i,
  input  cache_pkg::cpu_rsp_t  dcache_rsp_i,
  input  logic                 dcache_busy_i,
  input  logic [31:0]          dcache_exp_rdata_i,
  input  logic                 dcache_exp_hit_i,
  input  cache_pkg::cpu_req_t  icache_req_i,
  input  cache_pkg::cpu_rsp_t  icache_rsp_i,
  input  logic                 icache_busy_i,
  input  logic [31:0]          icache_exp_rdata_i,
  input  logic                 icache_exp_hit_i,
  output int                   error_count_o,
  output int                   check_count_o
);
  import cache_pkg::*;

  localparam int HIT_CYCLES = 2;

  int          cycle = 0;
  int          errors = 0;
  int          checks = 0;
  logic        in_reset = 1'b0;
  logic        pending [2] = '{1'b0, 1'b0};
  int          accept_cycle [2];
  logic        we_q [2];
  logic [13:0] addr_q [2];
  logic [31:0] exp_rdata_q [2];
  logic        exp_hit_q [2];

  assign error_count_o = errors;
  assign check_count_o = checks;

  task automatic check_reset_state();
    if (dcache_busy_i || icache_busy_i || dcache_rsp_i.done || icache_rsp_i.done) begin
      errors++;
      $display("** Error at %0t: after reset busy d=%0b i=%0b done d=%0b i=%0b, expected all low",
               $time, dcache_busy_i, icache_busy_i, dcache_rsp_i.done, icache_rsp_i.done);
    end
  endtask

  // Latches the access at acceptance, judges it at done
  task automatic track_port(input int port, input string name, input cpu_req_t req,
                            input cpu_rsp_t rsp, input logic busy,
                            input logic [31:0] exp_rdata, input logic exp_hit);
    int latency;
    if (rsp.done) begin
      if (!pending[port]) begin
        errors++;
        $display("** Error at %0t: %s raised done with no accepted request", $time, name);
      end else begin
        checks++;
        latency = cycle - accept_cycle[port];
        if (exp_hit_q[port] && latency != HIT_CYCLES) begin
          errors++;
          $display("** Error at %0t: %s access to 0x%04h took %0d cycles, expected a hit in %0d",
                   $time, name, addr_q[port], latency, HIT_CYCLES);
        end else if (!exp_hit_q[port] && latency <= HIT_CYCLES) begin
          errors++;
          $display("** Error at %0t: %s access to 0x%04h took %0d cycles, expected a miss",
                   $time, name, addr_q[port], latency);
        end
        if (!we_q[port] && rsp.rdata !== exp_rdata_q[port]) begin
          errors++;
          $display("** Error at %0t: %s read of 0x%04h returned 0x%08h, expected 0x%08h",
                   $time, name, addr_q[port], rsp.rdata, exp_rdata_q[port]);
        end
      end
      pending[port] = 1'b0;
    end else if (req.valid && !busy && !pending[port]) begin
      pending[port]      = 1'b1;
      accept_cycle[port] = cycle;
      we_q[port]         = req.we;
      addr_q[port]       = req.addr;
      exp_rdata_q[port]  = exp_rdata;
      exp_hit_q[port]    = exp_hit;
    end
  endtask

  // Mid-cycle sampling, all outputs settled
  always @(negedge clk_i) begin
    cycle++;
    if (rst_i) begin
      in_reset   = 1'b1;
      pending[0] = 1'b0;
      pending[1] = 1'b0;
    end else begin
      if (in_reset) begin
        check_reset_state();
        in_reset = 1'b0;
      end
      track_port(0, "dcache", dcache_req_i, dcache_rsp_i, dcache_busy_i,
                 dcache_exp_rdata_i, dcache_exp_hit_i);
      track_port(1, "icache", icache_req_i, icache_rsp_i, icache_busy_i,
                 icache_exp_rdata_i, icache_exp_hit_i);
    end
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Released just after an edge, ahead of the stimulus
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

`default_nettype wire
